// File: hw/mm_ram_pkg.sv
// Memory map and constants for the shared-RAM test harness
// Covers the RAM size, the virtual peripheral addresses and the
// magic values that the test status register understands

package mm_ram_pkg;

    // ----------------------------------------------------------------------
    // RAM geometry
    // ----------------------------------------------------------------------
    // Byte address width, 64 KiB of storage
    localparam int RAM_ADDR_WIDTH = 16;
    // Word address width for the 32-bit ports
    localparam int RAM_WORD_AW    = RAM_ADDR_WIDTH - 2;
    localparam int RAM_WORDS      = 2 ** RAM_WORD_AW;

    // ----------------------------------------------------------------------
    // Virtual peripheral addresses
    // ----------------------------------------------------------------------
    localparam logic [31:0] PRINT_ADDR  = 32'h1000_0000;
    localparam logic [31:0] DEBUG_ADDR  = 32'h1500_0000;
    localparam logic [31:0] STATUS_ADDR = 32'h2000_0000;
    localparam logic [31:0] EXIT_ADDR   = 32'h2000_0004;

    // Values written to STATUS_ADDR by the firmware
    localparam logic [31:0] TEST_PASS_VAL = 32'd123456789;
    localparam logic [31:0] TEST_FAIL_VAL = 32'd1;

    // ----------------------------------------------------------------------
    // Peripheral select codes between decoder and peripherals
    // ----------------------------------------------------------------------
    localparam int          VP_SEL_WIDTH = 2;
    localparam logic [1:0]  VP_SEL_PRINT  = 2'd0;
    localparam logic [1:0]  VP_SEL_STATUS = 2'd1;
    localparam logic [1:0]  VP_SEL_EXIT   = 2'd2;
    localparam logic [1:0]  VP_SEL_DEBUG  = 2'd3;

endpackage : mm_ram_pkg

// File: hw/dp_ram.sv
// Dual-port byte-lane RAM
// Port A is a read-only fetch port, port B reads or writes with
// byte enables. Both ports register their read data.

module dp_ram
    import mm_ram_pkg::*;
(
    input  logic                   clk_i,

    // Port A, instruction fetch
    input  logic                   a_en_i,
    input  logic [RAM_WORD_AW-1:0] a_addr_i,
    output logic [31:0]            a_rdata_o,

    // Port B, data access
    input  logic                   b_en_i,
    input  logic                   b_we_i,
    input  logic [3:0]             b_be_i,
    input  logic [RAM_WORD_AW-1:0] b_addr_i,
    input  logic [31:0]            b_wdata_i,
    output logic [31:0]            b_rdata_o
);

    // Word array split into byte lanes
    logic [3:0][7:0] mem [RAM_WORDS];

    logic [3:0][7:0] b_wdata_lanes;

    assign b_wdata_lanes = b_wdata_i;

    // ----------------------------------------------------------------------
    // Port A
    // ----------------------------------------------------------------------
    // Nonblocking read, so a same-cycle write on B leaves the old word here
    always_ff @(posedge clk_i) begin
        if (a_en_i) begin
            a_rdata_o <= mem[a_addr_i];
        end
    end

    // ----------------------------------------------------------------------
    // Port B
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (b_en_i) begin
            if (b_we_i) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (b_be_i[lane]) begin
                        mem[b_addr_i][lane] <= b_wdata_lanes[lane];
                    end
                end
            end
            b_rdata_o <= mem[b_addr_i];
        end
    end

    // A write with no lanes selected means the core built a bad request
    a_b_write_has_lanes : assert property (
        @(posedge clk_i) (b_en_i && b_we_i) |-> (b_be_i != 4'b0000)
    ) else $error("dp_ram: port B write with empty byte enable");

endmodule : dp_ram

// File: hw/data_decode.sv
// Data bus decoder
// Steers each data access to the RAM or to a virtual peripheral,
// grants immediately and returns the response one cycle later

module data_decode
    import mm_ram_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_i,

    // Data bus from the core
    input  logic                    data_req_i,
    input  logic [31:0]             data_addr_i,
    input  logic                    data_we_i,
    input  logic [3:0]              data_be_i,
    input  logic [31:0]             data_wdata_i,
    output logic                    data_gnt_o,
    output logic                    data_rvalid_o,
    output logic [31:0]             data_rdata_o,

    // RAM port B
    output logic                    ram_en_o,
    output logic                    ram_we_o,
    output logic [3:0]              ram_be_o,
    output logic [RAM_WORD_AW-1:0]  ram_addr_o,
    output logic [31:0]             ram_wdata_o,
    input  logic [31:0]             ram_rdata_i,

    // Virtual peripherals
    output logic                    vp_wr_o,
    output logic [VP_SEL_WIDTH-1:0] vp_sel_o,
    output logic [31:0]             vp_wdata_o
);

    logic ram_hit;
    logic vp_hit;
    logic rvalid_q;
    logic rd_ram_q;

    // ----------------------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------------------
    // Anything below the RAM size lands in the RAM
    assign ram_hit = (data_addr_i[31:RAM_ADDR_WIDTH] == '0);

    always_comb begin
        vp_hit   = 1'b1;
        vp_sel_o = VP_SEL_PRINT;
        case (data_addr_i)
            PRINT_ADDR:  vp_sel_o = VP_SEL_PRINT;
            STATUS_ADDR: vp_sel_o = VP_SEL_STATUS;
            EXIT_ADDR:   vp_sel_o = VP_SEL_EXIT;
            DEBUG_ADDR:  vp_sel_o = VP_SEL_DEBUG;
            // Unmapped, writes are dropped and reads give zero
            default:     vp_hit   = 1'b0;
        endcase
    end

    // Memory never stalls
    assign data_gnt_o = data_req_i;

    // RAM port B
    assign ram_en_o    = data_req_i && ram_hit;
    assign ram_we_o    = data_req_i && ram_hit && data_we_i;
    assign ram_be_o    = data_be_i;
    assign ram_addr_o  = data_addr_i[RAM_ADDR_WIDTH-1:2];
    assign ram_wdata_o = data_wdata_i;

    // Peripheral write strobe in the request cycle
    assign vp_wr_o    = data_req_i && data_we_i && vp_hit;
    assign vp_wdata_o = data_wdata_i;

    // ----------------------------------------------------------------------
    // Response
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rvalid_q <= 1'b0;
            rd_ram_q <= 1'b0;
        end else begin
            rvalid_q <= data_req_i;
            // Only RAM reads carry data back
            rd_ram_q <= data_req_i && ram_hit && !data_we_i;
        end
    end

    assign data_rvalid_o = rvalid_q;
    assign data_rdata_o  = rd_ram_q ? ram_rdata_i : 32'h0;

    a_addr_known : assert property (
        @(posedge clk_i) disable iff (rst_i)
        data_req_i |-> !$isunknown(data_addr_i)
    ) else $error("data_decode: data_addr_i unknown during a request");

endmodule : data_decode

// File: hw/vp_periph.sv
// Virtual peripherals of the test harness
// Character output, pass/fail status, exit code and debug request,
// all written through the data bus decoder

module vp_periph
    import mm_ram_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_i,

    input  logic                    vp_wr_i,
    input  logic [VP_SEL_WIDTH-1:0] vp_sel_i,
    input  logic [31:0]             vp_wdata_i,

    output logic                    stdout_valid_o,
    output logic [7:0]              stdout_char_o,
    output logic                    tests_passed_o,
    output logic                    tests_failed_o,
    output logic                    exit_valid_o,
    output logic [31:0]             exit_value_o,
    output logic                    debug_req_o
);

    logic wr_print;
    logic wr_status;
    logic wr_exit;
    logic wr_debug;
    logic verdict_open;

    assign wr_print  = vp_wr_i && (vp_sel_i == VP_SEL_PRINT);
    assign wr_status = vp_wr_i && (vp_sel_i == VP_SEL_STATUS);
    assign wr_exit   = vp_wr_i && (vp_sel_i == VP_SEL_EXIT);
    assign wr_debug  = vp_wr_i && (vp_sel_i == VP_SEL_DEBUG);

    // First verdict written sticks until reset
    assign verdict_open = !tests_passed_o && !tests_failed_o;

    // ----------------------------------------------------------------------
    // Pulses and sticky flags
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stdout_valid_o <= 1'b0;
            debug_req_o    <= 1'b0;
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
        end else begin
            stdout_valid_o <= wr_print;
            debug_req_o    <= wr_debug;
            if (wr_status && verdict_open) begin
                tests_passed_o <= (vp_wdata_i == TEST_PASS_VAL);
                tests_failed_o <= (vp_wdata_i == TEST_FAIL_VAL);
            end
            if (wr_exit) begin
                exit_valid_o <= 1'b1;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk_i) begin
        if (wr_print) begin
            stdout_char_o <= vp_wdata_i[7:0];
        end
        if (wr_exit) begin
            exit_value_o <= vp_wdata_i;
        end
    end

    a_verdict_exclusive : assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(tests_passed_o && tests_failed_o)
    ) else $error("vp_periph: passed and failed both set");

    a_exit_sticky : assert property (
        @(posedge clk_i) $fell(exit_valid_o) |-> $past(rst_i)
    ) else $error("vp_periph: exit_valid_o dropped without reset");

endmodule : vp_periph

// File: hw/mm_ram.sv
// Memory wrapper for a core test harness
// Serves the instruction and data buses from one shared RAM and
// maps the virtual peripherals onto the data bus

module mm_ram
    import mm_ram_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,

    // Instruction bus
    input  logic        instr_req_i,
    input  logic [31:0] instr_addr_i,
    output logic        instr_gnt_o,
    output logic        instr_rvalid_o,
    output logic [31:0] instr_rdata_o,

    // Data bus
    input  logic        data_req_i,
    input  logic [31:0] data_addr_i,
    input  logic        data_we_i,
    input  logic [3:0]  data_be_i,
    input  logic [31:0] data_wdata_i,
    output logic        data_gnt_o,
    output logic        data_rvalid_o,
    output logic [31:0] data_rdata_o,

    // Virtual peripheral outputs
    output logic        stdout_valid_o,
    output logic [7:0]  stdout_char_o,
    output logic        tests_passed_o,
    output logic        tests_failed_o,
    output logic        exit_valid_o,
    output logic [31:0] exit_value_o,
    output logic        debug_req_o
);

    logic [RAM_WORD_AW-1:0]  instr_word_addr;

    logic                    ram_en;
    logic                    ram_we;
    logic [3:0]              ram_be;
    logic [RAM_WORD_AW-1:0]  ram_addr;
    logic [31:0]             ram_wdata;
    logic [31:0]             ram_rdata;

    logic                    vp_wr;
    logic [VP_SEL_WIDTH-1:0] vp_sel;
    logic [31:0]             vp_wdata;

    // ----------------------------------------------------------------------
    // Instruction bus
    // ----------------------------------------------------------------------
    assign instr_gnt_o = instr_req_i;

    // Bits above the RAM range wrap
    assign instr_word_addr = instr_addr_i[RAM_ADDR_WIDTH-1:2];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            instr_rvalid_o <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
        end
    end

    // ----------------------------------------------------------------------
    // Data path and storage
    // ----------------------------------------------------------------------
    data_decode u_decode (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .data_req_i   (data_req_i),
        .data_addr_i  (data_addr_i),
        .data_we_i    (data_we_i),
        .data_be_i    (data_be_i),
        .data_wdata_i (data_wdata_i),
        .data_gnt_o   (data_gnt_o),
        .data_rvalid_o(data_rvalid_o),
        .data_rdata_o (data_rdata_o),
        .ram_en_o     (ram_en),
        .ram_we_o     (ram_we),
        .ram_be_o     (ram_be),
        .ram_addr_o   (ram_addr),
        .ram_wdata_o  (ram_wdata),
        .ram_rdata_i  (ram_rdata),
        .vp_wr_o      (vp_wr),
        .vp_sel_o     (vp_sel),
        .vp_wdata_o   (vp_wdata)
    );

    dp_ram u_ram (
        .clk_i    (clk_i),
        .a_en_i   (instr_req_i),
        .a_addr_i (instr_word_addr),
        .a_rdata_o(instr_rdata_o),
        .b_en_i   (ram_en),
        .b_we_i   (ram_we),
        .b_be_i   (ram_be),
        .b_addr_i (ram_addr),
        .b_wdata_i(ram_wdata),
        .b_rdata_o(ram_rdata)
    );

    vp_periph u_periph (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .vp_wr_i       (vp_wr),
        .vp_sel_i      (vp_sel),
        .vp_wdata_i    (vp_wdata),
        .stdout_valid_o(stdout_valid_o),
        .stdout_char_o (stdout_char_o),
        .tests_passed_o(tests_passed_o),
        .tests_failed_o(tests_failed_o),
        .exit_valid_o  (exit_valid_o),
        .exit_value_o  (exit_value_o),
        .debug_req_o   (debug_req_o)
    );

    a_instr_aligned : assert property (
        @(posedge clk_i) disable iff (rst_i)
        instr_req_i |-> (instr_addr_i[1:0] == 2'b00)
    ) else $error("mm_ram: misaligned instruction fetch");

endmodule : mm_ram

// File: verif/tb_mm_ram_tasks.svh
// Bus driving tasks for the mm_ram testbench
// Each task drives on the falling edge and waits for the grant

`ifndef TB_MM_RAM_TASKS_SVH
`define TB_MM_RAM_TASKS_SVH

localparam int WAIT_LIMIT = 50;

function automatic bit in_ram(input logic [31:0] addr);
    return addr < (32'd1 << RAM_ADDR_WIDTH);
endfunction

// Model word read, unwritten bytes give zero
function automatic logic [31:0] model_read(input logic [31:0] addr);
    logic [31:0] word;
    logic [31:0] key;
    for (int b = 0; b < 4; b++) begin
        key = {addr[31:2], 2'(b)};
        word[8*b +: 8] = model_mem.exists(key) ? model_mem[key] : 8'h00;
    end
    return word;
endfunction

task automatic model_write(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata);
    for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
            model_mem[{addr[31:2], 2'(b)}] = wdata[8*b +: 8];
        end
    end
endtask

task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s", what);
    $display("TESTBENCH FAILED");
    $finish;
endtask

// One bus cycle on either or both buses
task automatic bus_cycle(input bit i_req, input logic [31:0] i_addr,
                         input bit d_req, input logic [31:0] d_addr,
                         input bit d_we, input logic [3:0] d_be,
                         input logic [31:0] d_wdata);
    int n;
    @(negedge clk_i);
    instr_req_i  = i_req;
    instr_addr_i = i_addr;
    data_req_i   = d_req;
    data_addr_i  = d_addr;
    data_we_i    = d_we;
    data_be_i    = d_be;
    data_wdata_i = d_wdata;
    // Fetch sees the old word when a write hits it in the same cycle
    if (i_req) begin
        exp_i_next = model_read({16'h0, i_addr[RAM_ADDR_WIDTH-1:0]});
    end
    exp_d_next = (d_req && !d_we && in_ram(d_addr)) ? model_read(d_addr) : 32'h0;
    if (d_req && d_we && in_ram(d_addr)) begin
        model_write(d_addr, d_be, d_wdata);
    end
    n = 0;
    @(posedge clk_i);
    while ((i_req && !instr_gnt_o) || (d_req && !data_gnt_o)) begin
        n++;
        if (n > WAIT_LIMIT) begin
            timeout_fail("bus grant");
        end
        @(posedge clk_i);
    end
endtask

task automatic idle_cycle();
    bus_cycle(1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 4'h0, 32'h0);
endtask

// Let all pending responses come back
task automatic drain();
    int n;
    idle_cycle();
    n = 0;
    while (instr_rvalid_o || data_rvalid_o) begin
        n++;
        if (n > WAIT_LIMIT) begin
            timeout_fail("the buses to go idle");
        end
        @(posedge clk_i);
    end
endtask

`endif

// File: verif/tb_mm_ram.sv
// Testbench for the shared-RAM memory wrapper
// Acts as the core on both buses and checks responses and
// peripheral outputs against a byte-level reference model

module tb_mm_ram
    import mm_ram_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk_i, rst_i;
    logic        instr_req_i, instr_gnt_o, instr_rvalid_o;
    logic [31:0] instr_addr_i, instr_rdata_o;
    logic        data_req_i, data_we_i, data_gnt_o, data_rvalid_o;
    logic [3:0]  data_be_i;
    logic [31:0] data_addr_i, data_wdata_i, data_rdata_o;
    logic        stdout_valid_o, tests_passed_o, tests_failed_o;
    logic        exit_valid_o, debug_req_o;
    logic [7:0]  stdout_char_o;
    logic [31:0] exit_value_o;

    // Reference model state
    logic [7:0]  model_mem [logic [31:0]];
    logic [31:0] exp_i_next, exp_d_next, exp_i_rdata, exp_d_rdata;
    logic        exp_i_rvalid, exp_d_rvalid, exp_stdout, exp_debug;
    logic        exp_passed, exp_failed, exp_exit;
    logic [7:0]  exp_char;
    logic [31:0] exp_exit_value;
    logic        d_wr;
    int          err_cnt = 0;
    int          tests_done = 0;
    int          char_cnt = 0;
    int          seed = 32'hbf42_8132;

    `include "tb_mm_ram_tasks.svh"

    mm_ram u_dut (.*);

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    assign d_wr = data_req_i && data_we_i;

    always @(posedge clk_i) begin
        if (rst_i) begin
            {exp_i_rvalid, exp_d_rvalid, exp_stdout, exp_debug} <= '0;
            {exp_passed, exp_failed, exp_exit} <= '0;
        end else begin
            exp_i_rvalid <= instr_req_i;
            exp_d_rvalid <= data_req_i;
            exp_i_rdata  <= exp_i_next;
            exp_d_rdata  <= exp_d_next;
            exp_stdout   <= d_wr && data_addr_i == PRINT_ADDR;
            exp_char     <= data_wdata_i[7:0];
            exp_debug    <= d_wr && data_addr_i == DEBUG_ADDR;
            if (d_wr && data_addr_i == STATUS_ADDR && !exp_passed && !exp_failed) begin
                exp_passed <= data_wdata_i == TEST_PASS_VAL;
                exp_failed <= data_wdata_i == TEST_FAIL_VAL;
            end
            if (d_wr && data_addr_i == EXIT_ADDR) begin
                exp_exit       <= 1'b1;
                exp_exit_value <= data_wdata_i;
            end
            if (stdout_valid_o) char_cnt <= char_cnt + 1;
        end
    end

    task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("** Error @%0t ns: %s expected %h got %h", $time, sig, exp_v, act_v);
        err_cnt++;
    endtask

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    a_i_rvalid : assert property (@(posedge clk_i) disable iff (rst_i)
        instr_rvalid_o == exp_i_rvalid)
        else report_mismatch("instr_rvalid_o", $sampled(exp_i_rvalid), $sampled(instr_rvalid_o));
    a_i_rdata : assert property (@(posedge clk_i) disable iff (rst_i)
        instr_rvalid_o |-> instr_rdata_o == exp_i_rdata)
        else report_mismatch("instr_rdata_o", $sampled(exp_i_rdata), $sampled(instr_rdata_o));
    a_d_rvalid : assert property (@(posedge clk_i) disable iff (rst_i)
        data_rvalid_o == exp_d_rvalid)
        else report_mismatch("data_rvalid_o", $sampled(exp_d_rvalid), $sampled(data_rvalid_o));
    a_d_rdata : assert property (@(posedge clk_i) disable iff (rst_i)
        data_rvalid_o |-> data_rdata_o == exp_d_rdata)
        else report_mismatch("data_rdata_o", $sampled(exp_d_rdata), $sampled(data_rdata_o));
    a_stdout : assert property (@(posedge clk_i) disable iff (rst_i)
        stdout_valid_o == exp_stdout)
        else report_mismatch("stdout_valid_o", $sampled(exp_stdout), $sampled(stdout_valid_o));
    a_char : assert property (@(posedge clk_i) disable iff (rst_i)
        stdout_valid_o |-> stdout_char_o == exp_char)
        else report_mismatch("stdout_char_o", $sampled(exp_char), $sampled(stdout_char_o));
    a_debug : assert property (@(posedge clk_i) disable iff (rst_i)
        debug_req_o == exp_debug)
        else report_mismatch("debug_req_o", $sampled(exp_debug), $sampled(debug_req_o));
    a_passed : assert property (@(posedge clk_i) disable iff (rst_i)
        tests_passed_o == exp_passed)
        else report_mismatch("tests_passed_o", $sampled(exp_passed), $sampled(tests_passed_o));
    a_failed : assert property (@(posedge clk_i) disable iff (rst_i)
        tests_failed_o == exp_failed)
        else report_mismatch("tests_failed_o", $sampled(exp_failed), $sampled(tests_failed_o));
    a_exit : assert property (@(posedge clk_i) disable iff (rst_i)
        exit_valid_o == exp_exit)
        else report_mismatch("exit_valid_o", $sampled(exp_exit), $sampled(exit_valid_o));
    a_exit_val : assert property (@(posedge clk_i) disable iff (rst_i)
        exit_valid_o |-> exit_value_o == exp_exit_value)
        else report_mismatch("exit_value_o", $sampled(exp_exit_value), $sampled(exit_value_o));

    task automatic end_test(input string name);
        tests_done++;
        $display("Test %0d %s finished, %0d errors so far", tests_done, name, err_cnt);
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        string msg;
        logic [31:0] rnd, rnd2;
        msg = "mm_ram says hi\n";
        {instr_req_i, data_req_i, data_we_i, data_be_i} = '0;
        {instr_addr_i, data_addr_i, data_wdata_i} = '0;
        exp_i_next = '0;
        exp_d_next = '0;
        rst_i = 1'b1;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        repeat (4) idle_cycle();
        end_test("reset state");

        // Fill 64 words fully, then merge partial writes and read back
        for (int w = 0; w < 64; w++) begin
            bus_cycle(0, 0, 1, w * 4, 1, 4'hf, $random(seed));
        end
        for (int w = 0; w < 64; w++) begin
            rnd = $random(seed);
            bus_cycle(0, 0, 1, rnd[7:2] * 4, 1, (rnd[11:8] == 0) ? 4'h5 : rnd[11:8],
                      $random(seed));
        end
        for (int w = 0; w < 64; w++) begin
            bus_cycle(0, 0, 1, w * 4, 0, 4'hf, 0);
        end
        bus_cycle(0, 0, 1, 32'h0001_0000, 1, 4'hf, 32'hdead_beef);
        bus_cycle(0, 0, 1, 32'h0001_0000, 0, 4'hf, 0);
        bus_cycle(0, 0, 1, 32'h3000_0000, 0, 4'hf, 0);
        drain();
        end_test("data write and read");

        for (int w = 0; w < 16; w++) begin
            bus_cycle(1, w * 4, 0, 0, 0, 0, 0);
        end
        bus_cycle(1, 32'h20, 1, 32'h20, 1, 4'hf, 32'h1234_5678);
        bus_cycle(1, 32'h20, 0, 0, 0, 0, 0);
        drain();
        end_test("instruction fetch");

        for (int c = 0; c < msg.len(); c++) begin
            bus_cycle(0, 0, 1, PRINT_ADDR, 1, 4'h1, {24'h0, msg[c]});
        end
        drain();
        a_char_count : assert (char_cnt == msg.len())
            else report_mismatch("stdout pulse count", msg.len(), char_cnt);
        end_test("character output");

        bus_cycle(0, 0, 1, DEBUG_ADDR, 1, 4'hf, 32'h1);
        bus_cycle(0, 0, 1, STATUS_ADDR, 1, 4'hf, TEST_PASS_VAL);
        bus_cycle(0, 0, 1, EXIT_ADDR, 1, 4'hf, $random(seed));
        repeat (5) idle_cycle();
        drain();
        end_test("status and debug");

        for (int k = 0; k < 200; k++) begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            bus_cycle(rnd[0], rnd[7:2] * 4, rnd[1], rnd[13:8] * 4, rnd[14],
                      (rnd[19:16] == 0) ? 4'hc : rnd[19:16], rnd2);
        end
        drain();
        end_test("random traffic");

        $display("Tests run %0d, errors %0d", tests_done, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : tb_mm_ram

// File: all.f
+incdir+verif
hw/mm_ram_pkg.sv
hw/dp_ram.sv
hw/data_decode.sv
hw/vp_periph.sv
hw/mm_ram.sv
verif/tb_mm_ram.sv

// File: Bender.yml
package:
  name: mm_ram

sources:
  - hw/mm_ram_pkg.sv
  - hw/dp_ram.sv
  - hw/data_decode.sv
  - hw/vp_periph.sv
  - hw/mm_ram.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_mm_ram.sv
